/* Makefile */
BIN  := obj_dir/Vfifo_tb
SRCS := $(wildcard source/*.sv tests/*.sv)

.PHONY: all run clean

all: run

$(BIN): src.f $(SRCS)
	verilator --binary --assert --top-module fifo_tb -f src.f

run: $(BIN)
	./$(BIN) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log || { echo "no pass line in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log

/* source/fifo_1r1w_top.sv */
module fifo_1r1w_top
#(
  parameter int DATA_W = fifo_pkg::DATA_W_DEFAULT,
  parameter int DEPTH  = fifo_pkg::DEPTH_DEFAULT
)
(
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  logic               in_valid_i,
  input  logic [DATA_W-1:0]  in_data_i,
  output logic               in_ready_o,

  output logic               out_valid_o,
  output logic [DATA_W-1:0]  out_data_o,
  input  logic               out_ready_i
);

  localparam int ADDR_W = $clog2(DEPTH);

  logic              mem_w_v;
  logic [ADDR_W-1:0] mem_w_addr;
  logic [DATA_W-1:0] mem_w_data;
  logic              mem_r_v;
  logic [ADDR_W-1:0] mem_r_addr;
  logic [DATA_W-1:0] mem_r_data;
  logic              rd_credit;

  // pointers, count and read issue.
  fifo_ptr_ctrl #(
    .DATA_W (DATA_W),
    .DEPTH  (DEPTH)
  ) u_ptr_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_data_i    (in_data_i),
    .in_ready_o   (in_ready_o),
    .rd_credit_i  (rd_credit),
    .mem_w_v_o    (mem_w_v),
    .mem_w_addr_o (mem_w_addr),
    .mem_w_data_o (mem_w_data),
    .mem_r_v_o    (mem_r_v),
    .mem_r_addr_o (mem_r_addr)
  );

  // storage, one cycle read latency.
  mem_1r1w_sync #(
    .DATA_W (DATA_W),
    .DEPTH  (DEPTH)
  ) u_mem (
    .clk_i    (clk_i),
    .w_v_i    (mem_w_v),
    .w_addr_i (mem_w_addr),
    .w_data_i (mem_w_data),
    .r_v_i    (mem_r_v),
    .r_addr_i (mem_r_addr),
    .r_data_o (mem_r_data)
  );

  // output staging.
  fifo_out_stage #(
    .DATA_W (DATA_W),
    .DEPTH  (DEPTH)
  ) u_out_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rd_issue_i  (mem_r_v),
    .rd_data_i   (mem_r_data),
    .rd_credit_o (rd_credit),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_ready_i (out_ready_i)
  );

endmodule

/* source/fifo_out_stage.sv */
module fifo_out_stage
#(
  parameter int DATA_W = fifo_pkg::DATA_W_DEFAULT,
  parameter int DEPTH  = fifo_pkg::DEPTH_DEFAULT
)
(
  input  logic               clk_i,
  input  logic               rst_n_i,

  // read issue and returning memory data.
  input  logic               rd_issue_i,
  input  logic [DATA_W-1:0]  rd_data_i,
  output logic               rd_credit_o,

  // consumer side.
  output logic               out_valid_o,
  output logic [DATA_W-1:0]  out_data_o,
  input  logic               out_ready_i
);

  import fifo_pkg::*;

  // slots hold at most two items regardless of depth.
  localparam int SLOTS = 2;

  out_state_e        state_q;
  logic              inflight_q;
  logic [DATA_W-1:0] slot_q [SLOTS];

  logic       push;
  logic       pop;
  logic [1:0] held_cnt;
  logic [2:0] occupancy;

  // memory data is meaningful one cycle after issue.
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      inflight_q <= 1'b0;
    end
    else
    begin
      inflight_q <= rd_issue_i;
    end
  end

  assign push = inflight_q;
  assign pop  = out_valid_o & out_ready_i;

  always_comb
  begin
    case (state_q)
      OUT_ONE: held_cnt = 2'd1;
      OUT_TWO: held_cnt = 2'd2;
      default: held_cnt = 2'd0;
    endcase
  end

  // the pop of this cycle frees a slot, which keeps full throughput.
  assign occupancy   = {1'b0, held_cnt} + {2'b00, inflight_q} - {2'b00, pop};
  assign rd_credit_o = (occupancy < 3'd2);

  // slot 0 is always the older item.
  assign out_valid_o = (state_q != OUT_EMPTY);
  assign out_data_o  = slot_q[0];

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= OUT_EMPTY;
    end
    else
    begin
      case (state_q)
        OUT_EMPTY:
        begin
          if (push)
          begin
            state_q <= OUT_ONE;
          end
        end
        OUT_ONE:
        begin
          if (push && !pop)
          begin
            state_q <= OUT_TWO;
          end
          else if (!push && pop)
          begin
            state_q <= OUT_EMPTY;
          end
        end
        OUT_TWO:
        begin
          // credit rules out a push without a pop here.
          if (pop && !push)
          begin
            state_q <= OUT_ONE;
          end
        end
        default:
        begin
          state_q <= OUT_EMPTY;
        end
      endcase
    end
  end

  // payload slots.
  always_ff @(posedge clk_i)
  begin
    if (state_q == OUT_TWO && pop)
    begin
      slot_q[0] <= slot_q[1];
      if (push)
      begin
        slot_q[1] <= rd_data_i;
      end
    end
    else if (push)
    begin
      if (state_q == OUT_EMPTY || (state_q == OUT_ONE && pop))
      begin
        slot_q[0] <= rd_data_i;
      end
      else
      begin
        slot_q[1] <= rd_data_i;
      end
    end
  end

endmodule

/* source/fifo_pkg.sv */
package fifo_pkg;

  // default payload width in bits.
  parameter int DATA_W_DEFAULT = 16;

  // default number of memory entries, power of two.
  parameter int DEPTH_DEFAULT = 16;

  // occupancy of the two-slot output buffer.
  typedef enum logic [1:0]
  {
    OUT_EMPTY = 2'd0,
    OUT_ONE   = 2'd1,
    OUT_TWO   = 2'd2
  } out_state_e;

endpackage

/* source/fifo_ptr_ctrl.sv */
module fifo_ptr_ctrl
#(
  parameter int DATA_W = fifo_pkg::DATA_W_DEFAULT,
  parameter int DEPTH  = fifo_pkg::DEPTH_DEFAULT
)
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  // producer side.
  input  logic                       in_valid_i,
  input  logic [DATA_W-1:0]          in_data_i,
  output logic                       in_ready_o,

  // credit from the output stage.
  input  logic                       rd_credit_i,

  // memory write port.
  output logic                       mem_w_v_o,
  output logic [$clog2(DEPTH)-1:0]   mem_w_addr_o,
  output logic [DATA_W-1:0]          mem_w_data_o,

  // memory read port, also the issue strobe.
  output logic                       mem_r_v_o,
  output logic [$clog2(DEPTH)-1:0]   mem_r_addr_o
);

  localparam int ADDR_W = $clog2(DEPTH);
  localparam int CNT_W  = ADDR_W + 1;

  logic [ADDR_W-1:0] wr_ptr_q;
  logic [ADDR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0]  count_q;

  logic wr_fire;
  logic rd_fire;

  // room left while fewer than DEPTH words are stored.
  assign in_ready_o = (count_q < CNT_W'(DEPTH));
  assign wr_fire    = in_valid_i & in_ready_o;

  // only entries written at an earlier edge are read.
  assign rd_fire    = (count_q != '0) & rd_credit_i;

  assign mem_w_v_o    = wr_fire;
  assign mem_w_addr_o = wr_ptr_q;
  assign mem_w_data_o = in_data_i;

  assign mem_r_v_o    = rd_fire;
  assign mem_r_addr_o = rd_ptr_q;

  // pointers wrap on their own since DEPTH is a power of two.
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (wr_fire)
      begin
        wr_ptr_q <= wr_ptr_q + ADDR_W'(1);
      end
      if (rd_fire)
      begin
        rd_ptr_q <= rd_ptr_q + ADDR_W'(1);
      end
    end
  end

  // stored word count.
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      count_q <= '0;
    end
    else
    begin
      case ({wr_fire, rd_fire})
        2'b10:
        begin
          count_q <= count_q + CNT_W'(1);
        end
        2'b01:
        begin
          count_q <= count_q - CNT_W'(1);
        end
        default:
        begin
          // no change, or a write and a read cancel.
          count_q <= count_q;
        end
      endcase
    end
  end

endmodule

/* source/mem_1r1w_sync.sv */
module mem_1r1w_sync
#(
  parameter int DATA_W = fifo_pkg::DATA_W_DEFAULT,
  parameter int DEPTH  = fifo_pkg::DEPTH_DEFAULT
)
(
  input  logic                       clk_i,

  input  logic                       w_v_i,
  input  logic [$clog2(DEPTH)-1:0]   w_addr_i,
  input  logic [DATA_W-1:0]          w_data_i,

  input  logic                       r_v_i,
  input  logic [$clog2(DEPTH)-1:0]   r_addr_i,
  output logic [DATA_W-1:0]          r_data_o
);

  localparam int ADDR_W = $clog2(DEPTH);

  logic [DATA_W-1:0] mem_q [DEPTH];
  logic [ADDR_W-1:0] r_addr;

  assign r_addr = r_addr_i;

  // write port.
  always_ff @(posedge clk_i)
  begin
    if (w_v_i)
    begin
      mem_q[w_addr_i] <= w_data_i;
    end
  end

  // read port, output holds between reads.
  always_ff @(posedge clk_i)
  begin
    if (r_v_i)
    begin
      r_data_o <= mem_q[r_addr];
    end
  end

endmodule

/* src.f */
source/fifo_pkg.sv
source/mem_1r1w_sync.sv
source/fifo_ptr_ctrl.sv
source/fifo_out_stage.sv
source/fifo_1r1w_top.sv
tests/tb_clock_gen.sv
tests/fifo_tb.sv

/* tests/fifo_tb.sv */
module fifo_tb;

  localparam int DATA_W     = 16;
  localparam int DEPTH      = 16;
  localparam int CAPACITY   = DEPTH + 2;
  localparam int CLK_PERIOD = 4;

  localparam int RESET_CYCLES  = 8;
  localparam int IDLE_CYCLES   = 3;
  localparam int SINGLE_CYCLES = 5;
  localparam int FILL_CYCLES   = DEPTH + 10;
  localparam int DRAIN_CYCLES  = CAPACITY + 8;
  localparam int SETTLE_CYCLES = 4;
  localparam int RANDOM_CYCLES = 2000;
  localparam int WARM_CYCLES   = 2 * DEPTH + 8;
  localparam int STREAM_CYCLES = 200;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + SINGLE_CYCLES + FILL_CYCLES
                               + 2 * (DRAIN_CYCLES + SETTLE_CYCLES + 1)
                               + RANDOM_CYCLES + WARM_CYCLES + STREAM_CYCLES;
  localparam int WATCHDOG_TIME = TOTAL_CYCLES * CLK_PERIOD + 200;

  logic              clk_i;
  logic              rst_n_i;
  logic              in_valid_i;
  logic [DATA_W-1:0] in_data_i;
  logic              in_ready_o;
  logic              out_valid_o;
  logic [DATA_W-1:0] out_data_o;
  logic              out_ready_i;

  integer            seed;
  logic [DATA_W-1:0] model_q [$];
  logic              seen_input;
  logic              in_xfer;
  logic              out_xfer;
  logic [DATA_W-1:0] exp_data;
  int                model_status;

  tb_clock_gen #(
    .PERIOD (CLK_PERIOD)
  ) u_clk_gen (
    .clk_o (clk_i)
  );

  fifo_1r1w_top #(
    .DATA_W (DATA_W),
    .DEPTH  (DEPTH)
  ) DUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_ready_i (out_ready_i)
  );

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED time=%0t signal=%s expected=0x%0h actual=0x%0h",
             $time, name, expected, actual);
    abort_run();
  endtask

  // reference queue of capacity DEPTH+2; pop comes first, the latency is never zero.
  // status 0 ok, 1 pop with nothing stored, 2 more items than the capacity.
  function automatic int model_step(input logic push, input logic [DATA_W-1:0] push_data,
                                    input logic pop, output logic [DATA_W-1:0] expected);
    int status;
    status   = 0;
    expected = '0;
    if (pop)
    begin
      if (model_q.size() == 0)
      begin
        status = 1;
      end
      else
      begin
        expected = model_q.pop_front();
      end
    end
    if (push)
    begin
      model_q.push_back(push_data);
      if (model_q.size() > CAPACITY)
      begin
        status = 2;
      end
    end
    return status;
  endfunction

  // compare every transfer against the model.
  always @(posedge clk_i)
  begin
    if (rst_n_i)
    begin
      in_xfer  = in_valid_i & in_ready_o;
      out_xfer = out_valid_o & out_ready_i;
      if (!seen_input)
      begin
        assert (in_ready_o == 1'b1)
        else report_mismatch("in_ready_o", 32'(1), 32'(in_ready_o));
        assert (out_valid_o == 1'b0)
        else report_mismatch("out_valid_o", 32'(0), 32'(out_valid_o));
      end
      model_status = model_step(in_xfer, in_data_i, out_xfer, exp_data);
      assert (model_status != 1)
      else
      begin
        $display("output 0x%0h at time %0t has no matching input item", out_data_o, $time);
        abort_run();
      end
      assert (model_status != 2)
      else
      begin
        $display("more than %0d items accepted at time %0t", CAPACITY, $time);
        abort_run();
      end
      if (out_xfer)
      begin
        assert (out_data_o == exp_data)
        else report_mismatch("out_data_o", 32'(exp_data), 32'(out_data_o));
      end
      if (in_xfer)
      begin
        seen_input = 1'b1;
      end
    end
  end

  task automatic send_single_item();
    logic [31:0]       rnd;
    logic [DATA_W-1:0] item;
    rnd  = $random(seed);
    item = rnd[DATA_W-1:0];
    @(negedge clk_i);
    in_valid_i  = 1'b1;
    in_data_i   = item;
    out_ready_i = 1'b1;
    // empty buffer, so this edge accepts the item.
    @(posedge clk_i);
    assert (in_ready_o == 1'b1)
    else report_mismatch("in_ready_o", 32'(1), 32'(in_ready_o));
    @(negedge clk_i);
    in_valid_i = 1'b0;
    repeat (2)
    begin
      assert (out_valid_o == 1'b0)
      else report_mismatch("out_valid_o", 32'(0), 32'(out_valid_o));
      @(negedge clk_i);
    end
    // two edges after acceptance.
    assert (out_valid_o == 1'b1)
    else report_mismatch("out_valid_o", 32'(1), 32'(out_valid_o));
    assert (out_data_o == item)
    else report_mismatch("out_data_o", 32'(item), 32'(out_data_o));
  endtask

  task automatic drain_all();
    int waited;
    @(negedge clk_i);
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    waited      = 0;
    while (model_q.size() != 0 && waited < DRAIN_CYCLES)
    begin
      @(negedge clk_i);
      waited++;
    end
    assert (model_q.size() == 0)
    else
    begin
      $display("buffer still holds items after %0d drain cycles", DRAIN_CYCLES);
      abort_run();
    end
    repeat (SETTLE_CYCLES)
    begin
      @(negedge clk_i);
      assert (in_ready_o == 1'b1)
      else report_mismatch("in_ready_o", 32'(1), 32'(in_ready_o));
      assert (out_valid_o == 1'b0)
      else report_mismatch("out_valid_o", 32'(0), 32'(out_valid_o));
    end
  endtask

  task automatic fill_and_drain();
    int          i;
    int          accepted;
    logic        xfer;
    logic [31:0] rnd;
    accepted = 0;
    @(negedge clk_i);
    rnd         = $random(seed);
    out_ready_i = 1'b0;
    in_valid_i  = 1'b1;
    in_data_i   = rnd[DATA_W-1:0];
    for (i = 0; i < FILL_CYCLES; i++)
    begin
      @(posedge clk_i);
      xfer = in_valid_i & in_ready_o;
      @(negedge clk_i);
      if (xfer)
      begin
        accepted++;
        rnd       = $random(seed);
        in_data_i = rnd[DATA_W-1:0];
      end
    end
    assert (accepted == CAPACITY)
    else report_mismatch("accepted item count", 32'(CAPACITY), 32'(accepted));
    assert (in_ready_o == 1'b0)
    else report_mismatch("in_ready_o", 32'(0), 32'(in_ready_o));
    in_valid_i = 1'b0;
    drain_all();
  endtask

  task automatic random_traffic();
    int          i;
    logic        xfer;
    logic [31:0] rnd;
    for (i = 0; i < RANDOM_CYCLES; i++)
    begin
      @(posedge clk_i);
      xfer = in_valid_i & in_ready_o;
      @(negedge clk_i);
      rnd = $random(seed);
      // a pending item is held until it transfers.
      if (xfer || !in_valid_i)
      begin
        in_valid_i = (rnd[1:0] != 2'b00);
        in_data_i  = rnd[DATA_W+15:16];
      end
      // heavy back-pressure first, then a light one.
      if (i < RANDOM_CYCLES / 2)
      begin
        out_ready_i = rnd[2];
      end
      else
      begin
        out_ready_i = (rnd[4:2] != 3'b000);
      end
    end
  endtask

  task automatic full_rate_stream();
    int          i;
    int          base_len;
    logic        xfer;
    logic [31:0] rnd;
    if (!in_valid_i)
    begin
      rnd        = $random(seed);
      in_valid_i = 1'b1;
      in_data_i  = rnd[DATA_W-1:0];
    end
    out_ready_i = 1'b1;
    base_len    = 0;
    for (i = 0; i < WARM_CYCLES + STREAM_CYCLES; i++)
    begin
      if (i == WARM_CYCLES)
      begin
        base_len = model_q.size();
      end
      @(posedge clk_i);
      xfer = in_valid_i & in_ready_o;
      if (i >= WARM_CYCLES)
      begin
        assert (in_ready_o == 1'b1)
        else report_mismatch("in_ready_o", 32'(1), 32'(in_ready_o));
        assert (out_valid_o == 1'b1)
        else report_mismatch("out_valid_o", 32'(1), 32'(out_valid_o));
      end
      @(negedge clk_i);
      if (xfer)
      begin
        rnd       = $random(seed);
        in_data_i = rnd[DATA_W-1:0];
      end
      if (i >= WARM_CYCLES)
      begin
        assert (model_q.size() == base_len)
        else report_mismatch("model queue length", 32'(base_len), 32'(model_q.size()));
      end
    end
  endtask

  // watchdog.
  initial
  begin
    #(WATCHDOG_TIME);
    $display("timeout, the run did not finish within %0d time units", WATCHDOG_TIME);
    abort_run();
  end

  initial
  begin
    seed        = 32'h98ea_b66f;
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    out_ready_i = 1'b0;
    seen_input  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (2) @(negedge clk_i);
    send_single_item();
    fill_and_drain();
    random_traffic();
    full_rate_stream();
    drain_all();
    if (model_q.size() == 0)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
    begin
      $display("%0d items never came out of the buffer", model_q.size());
      abort_run();
    end
  end

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen
#(
  parameter int PERIOD = 4
)
(
  output logic clk_o
);

  // free running clock, low at time zero.
  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #(PERIOD / 2) clk_o = ~clk_o;
    end
  end

endmodule
